// ==== bench/ssm_block_model.svh ====
/* reference model of the ssm block: q8.8 saturating arithmetic,
   the per-tile lane sum and the y of a closed group */
`ifndef SSM_BLOCK_MODEL_SVH
`define SSM_BLOCK_MODEL_SVH

// lanes of one tile, index n is lane n
typedef logic [N_TILE-1:0][ssm_pkg::FX_W-1:0] lanes_t;

localparam longint REF_MAX = 2 ** (ssm_pkg::FX_W - 1) - 1;   // +127.996 in q8.8
localparam longint REF_MIN = -(2 ** (ssm_pkg::FX_W - 1));    // -128.0

// clamp an exact value to the 16 bit range
function automatic ssm_pkg::fx_t ref_sat(input longint v);
    if (v > REF_MAX) begin
        return ssm_pkg::fx_t'(REF_MAX);
    end
    if (v < REF_MIN) begin
        return ssm_pkg::fx_t'(REF_MIN);
    end
    return ssm_pkg::fx_t'(v);
endfunction

// keep the whole product, drop 8 fraction bits with sign, then clamp
function automatic ssm_pkg::fx_t ref_mul(input ssm_pkg::fx_t a, input ssm_pkg::fx_t b);
    longint p;
    p = longint'(a) * longint'(b);
    return ref_sat(p >>> ssm_pkg::FX_FRAC);
endfunction

function automatic ssm_pkg::fx_t ref_add(input ssm_pkg::fx_t a, input ssm_pkg::fx_t b);
    return ref_sat(longint'(a) + longint'(b));
endfunction

// sum over the lanes of one tile of C * (dA * hprev + dx * B)
function automatic longint ref_tile_sum(input ssm_pkg::tile_scalars_t s,
                                        input lanes_t lb, input lanes_t lc,
                                        input lanes_t lh);
    ssm_pkg::fx_t delta;
    ssm_pkg::fx_t dx;
    ssm_pkg::fx_t h;
    longint       sum;
    delta = ref_add(s.dt, s.dt_bias);
    dx    = ref_mul(delta, s.x);        // own x of the tile
    sum   = 0;
    for (int n = 0; n < N_TILE; n++) begin
        h   = ref_add(ref_mul(s.da, lh[n]), ref_mul(dx, lb[n]));
        sum = sum + longint'(ref_mul(h, lc[n]));   // exact across lanes
    end
    return sum;
endfunction

// y of a group from its tile sums and the x and D of its first tile
function automatic ssm_pkg::fx_t ref_group_y(input longint tile_sums,
                                             input ssm_pkg::fx_t x_first,
                                             input ssm_pkg::fx_t d_first);
    return ref_sat(tile_sums + longint'(ref_mul(x_first, d_first)));
endfunction

`endif

// ==== bench/ssm_block_tb.sv ====
/* ssm block testbench with clock, reset, tile stimulus, model queue,
   comparing process, cycle limit and the run summary */
module ssm_block_tb;
    localparam int N_TILE          = 4;
    localparam int TILES_PER_GROUP = 2;
    localparam int TIMEOUT_CYCLES  = 60 * TILES_PER_GROUP * 25;   // ~60 groups, worst gaps, margin
    localparam int DRAIN_CYCLES    = 7 + 8;                       // y latency plus margin

    `include "ssm_block_model.svh"

    logic                   clk;
    logic                   rstn;
    logic                   tile_valid_i;
    ssm_pkg::tile_scalars_t scalars_i;
    ssm_pkg::fx_t           b_i     [N_TILE];
    ssm_pkg::fx_t           c_i     [N_TILE];
    ssm_pkg::fx_t           hprev_i [N_TILE];
    ssm_pkg::fx_t           y_o;
    logic                   y_valid_o;

    ssm_block_top #(
        .N_TILE          (N_TILE),
        .TILES_PER_GROUP (TILES_PER_GROUP)
    ) DUT (
        .clk          (clk),
        .rstn         (rstn),
        .tile_valid_i (tile_valid_i),
        .scalars_i    (scalars_i),
        .b_i          (b_i),
        .c_i          (c_i),
        .hprev_i      (hprev_i),
        .y_o          (y_o),
        .y_valid_o    (y_valid_o)
    );

    // ====================
    // bookkeeping
    integer       seed = 32'hde82;
    int           cycles = 0;        // rising edges so far
    int           errors = 0;
    int           checks = 0;
    int           passed = 0;
    int           failed = 0;
    int           test_num = 0;
    int           test_groups = 0;
    int           test_err_base = 0;
    ssm_pkg::fx_t exp_y_q [$];       // expected y in arrival order
    int           exp_edge_q [$];    // edge on which each y must show
    ssm_pkg::fx_t exp_y;
    int           exp_edge;
    int           tile_idx = 0;      // position in the current group
    longint       grp_sum;
    ssm_pkg::fx_t grp_x;
    ssm_pkg::fx_t grp_d;

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // cycle limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: stopped after %0d cycles, results still missing", cycles);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // ====================
    // comparing process on the falling edge
    always @(negedge clk) begin
        if (rstn && y_valid_o) begin
            if (exp_y_q.size() == 0) begin
                $display("error at time %0t: y_valid_o pulsed while no group result was due",
                         $time);
                errors++;
            end else begin
                exp_y    = exp_y_q.pop_front();
                exp_edge = exp_edge_q.pop_front();
                checks++;
                assert (y_o == exp_y) else begin
                    $display("[FAIL] time %0t: y_o is %0d, model gives %0d", $time, y_o, exp_y);
                    errors++;
                end
                assert (cycles == exp_edge) else begin
                    $display("[FAIL] time %0t: y_valid_o on edge %0d, due on edge %0d",
                             $time, cycles, exp_edge);
                    errors++;
                end
            end
        end
    end

    // ====================
    // stimulus helpers
    function automatic ssm_pkg::fx_t rand_fx();
        logic [31:0] r;
        r = $random(seed);
        return {{5{r[10]}}, r[10:0]};   // about -4.0 .. +4.0
    endfunction

    function automatic lanes_t rand_lanes();
        lanes_t l;
        for (int n = 0; n < N_TILE; n++) begin
            l[n] = rand_fx();
        end
        return l;
    endfunction

    function automatic ssm_pkg::tile_scalars_t rand_scalars();
        ssm_pkg::tile_scalars_t s;
        logic [31:0]            r;
        r         = $random(seed);
        s.dt      = rand_fx();
        s.dt_bias = rand_fx();
        s.da      = {8'h00, r[7:0]};    // decay in 0 .. 1
        s.x       = rand_fx();
        s.d       = rand_fx();
        return s;
    endfunction

    // idle for gap cycles, then present one tile; the model runs on the last tile
    task automatic send_tile(input ssm_pkg::tile_scalars_t ts, input lanes_t lb,
                             input lanes_t lc, input lanes_t lh, input int gap);
        repeat (gap) begin
            @(posedge clk);
            #10 tile_valid_i = 1'b0;
        end
        @(posedge clk);
        #10;
        tile_valid_i = 1'b1;
        scalars_i    = ts;
        for (int n = 0; n < N_TILE; n++) begin
            b_i[n]     = lb[n];
            c_i[n]     = lc[n];
            hprev_i[n] = lh[n];
        end
        if (tile_idx == 0) begin
            grp_x   = ts.x;        // xD of the group comes from here
            grp_d   = ts.d;
            grp_sum = 0;
        end
        grp_sum = grp_sum + ref_tile_sum(ts, lb, lc, lh);
        if (tile_idx == TILES_PER_GROUP - 1) begin
            exp_y_q.push_back(ref_group_y(grp_sum, grp_x, grp_d));
            exp_edge_q.push_back(cycles + 7);   // taking edge plus six
            test_groups++;
            tile_idx = 0;
        end else begin
            tile_idx++;
        end
    endtask

    task automatic send_random_group(input int max_gap);
        int gap;
        for (int t = 0; t < TILES_PER_GROUP; t++) begin
            gap = $unsigned($random(seed)) % (max_gap + 1);
            send_tile(rand_scalars(), rand_lanes(), rand_lanes(), rand_lanes(), gap);
        end
    endtask

    task automatic go_idle();
        @(posedge clk);
        #10 tile_valid_i = 1'b0;
    endtask

    // wait for the queued results within the y latency, then report the test
    task automatic finish_test(input string name);
        int errs;
        int waited;
        go_idle();
        waited = 0;
        while (exp_y_q.size() != 0 && waited < DRAIN_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        if (exp_y_q.size() != 0) begin
            $display("error: %0d results of test %s did not come out in time",
                     exp_y_q.size(), name);
            errors++;
        end
        repeat (4) @(negedge clk);          // room for a stray extra pulse
        errs = errors - test_err_base;
        test_num++;
        if (errs == 0) begin
            passed++;
        end else begin
            failed++;
        end
        $display("test %0d %s: %0d groups, %0d errors", test_num, name, test_groups, errs);
        test_err_base = errors;
        test_groups   = 0;
    endtask

    // ====================
    // test sequence
    ssm_pkg::tile_scalars_t ts;

    initial begin
        rstn         = 1'b0;
        tile_valid_i = 1'b0;
        scalars_i    = '0;
        for (int n = 0; n < N_TILE; n++) begin
            b_i[n]     = '0;
            c_i[n]     = '0;
            hprev_i[n] = '0;
        end
        repeat (3) @(posedge clk);
        #10 rstn = 1'b1;

        // quiet after reset, then one hand-picked group
        repeat (20) @(posedge clk);
        ts = '{dt: 16'sh0080, dt_bias: 16'sh0040, da: 16'sh0080, x: 16'sh0200, d: 16'sh0100};
        send_tile(ts, {16'h0040, 16'hff00, 16'h0080, 16'h0100},
                  {16'hff00, 16'h0080, 16'h0200, 16'h0100},
                  {16'h0200, 16'h0100, 16'hff80, 16'h0080}, 0);
        send_tile(ts, {16'h0100, 16'h0100, 16'hff80, 16'h0040},
                  {16'h0080, 16'h0100, 16'hff00, 16'h0200},
                  {16'hff00, 16'h0040, 16'h0100, 16'h0180}, 0);
        finish_test("after_reset");

        for (int g = 0; g < 10; g++) begin
            send_random_group(0);        // valid held high throughout
        end
        finish_test("back_to_back");

        // x and D move on every non-first tile
        for (int g = 0; g < 3; g++) begin
            for (int t = 0; t < TILES_PER_GROUP; t++) begin
                ts   = rand_scalars();
                ts.x = ssm_pkg::fx_t'(16'sh0100 + t * 16'sh0180 - g * 16'sh0040);
                ts.d = ssm_pkg::fx_t'(16'sh0200 - t * 16'sh0300 + g * 16'sh0020);
                send_tile(ts, rand_lanes(), rand_lanes(), rand_lanes(), 0);
            end
        end
        finish_test("first_tile_capture");

        // clamp high, then low through C
        ts = '{dt: 16'sh7000, dt_bias: 16'sh7000, da: 16'sh7fff, x: 16'sh4000, d: 16'sh7fff};
        for (int t = 0; t < TILES_PER_GROUP; t++) begin
            send_tile(ts, {N_TILE{16'h7fff}}, {N_TILE{16'h7fff}}, {N_TILE{16'h7fff}}, 0);
        end
        ts.d = 16'sh8000;
        for (int t = 0; t < TILES_PER_GROUP; t++) begin
            send_tile(ts, {N_TILE{16'h7fff}}, {N_TILE{16'h8000}}, {N_TILE{16'h7fff}}, 0);
        end
        finish_test("saturation");

        for (int g = 0; g < 10; g++) begin
            send_random_group(3);
        end
        finish_test("random_gaps");

        for (int g = 0; g < 40; g++) begin
            send_random_group(1);
        end
        finish_test("random_sweep");

        if (exp_y_q.size() != 0) begin
            $display("error: %0d expected results never came out", exp_y_q.size());
            errors++;
        end
        $display("summary: %0d tests, %0d passed, %0d failed, %0d checks, %0d errors",
                 test_num, passed, failed, checks, errors);
        if (errors == 0 && failed == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== design/ssm_block_top.sv ====
/* ssm block top: scalar stage, state update and group accumulator
   in series, seven cycles from the last tile of a group to y */
module ssm_block_top #(
    parameter int N_TILE          = 4,   // state lanes per tile
    parameter int TILES_PER_GROUP = 2    // tiles summed into one y
) (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   tile_valid_i,   // one tile per high cycle, no ready
    input  ssm_pkg::tile_scalars_t scalars_i,
    input  ssm_pkg::fx_t           b_i     [N_TILE],
    input  ssm_pkg::fx_t           c_i     [N_TILE],
    input  ssm_pkg::fx_t           hprev_i [N_TILE],
    output ssm_pkg::fx_t           y_o,
    output logic                   y_valid_o       // one pulse per group
);

    // ====================
    // scalar stage, 2 cycles
    logic                 sc_valid;
    ssm_pkg::scalar_out_t sc;
    ssm_pkg::fx_t         b     [N_TILE];
    ssm_pkg::fx_t         c     [N_TILE];
    ssm_pkg::fx_t         hprev [N_TILE];

    ssm_scalar_stage #(
        .N_TILE          (N_TILE),
        .TILES_PER_GROUP (TILES_PER_GROUP)
    ) u_scalar (
        .clk          (clk),
        .rstn         (rstn),
        .tile_valid_i (tile_valid_i),
        .scalars_i    (scalars_i),
        .b_i          (b_i),
        .c_i          (c_i),
        .hprev_i      (hprev_i),
        .sc_valid_o   (sc_valid),
        .sc_o         (sc),
        .b_o          (b),
        .c_o          (c),
        .hprev_o      (hprev)
    );

    // ====================
    // state update, 3 cycles
    logic         hc_valid;
    ssm_pkg::fx_t hc_tile [N_TILE];
    logic         hc_last;
    ssm_pkg::fx_t xd;

    ssm_state_update #(
        .N_TILE (N_TILE)
    ) u_state (
        .clk        (clk),
        .rstn       (rstn),
        .sc_valid_i (sc_valid),
        .sc_i       (sc),
        .b_i        (b),
        .c_i        (c),
        .hprev_i    (hprev),
        .hc_valid_o (hc_valid),
        .hc_tile_o  (hc_tile),
        .hc_last_o  (hc_last),
        .xd_o       (xd)
    );

    // ====================
    // group accumulator, 2 cycles
    ssm_group_accum #(
        .N_TILE (N_TILE)
    ) u_accum (
        .clk        (clk),
        .rstn       (rstn),
        .hc_valid_i (hc_valid),
        .hc_tile_i  (hc_tile),
        .hc_last_i  (hc_last),
        .xd_i       (xd),
        .y_o        (y_o),
        .y_valid_o  (y_valid_o)
    );

endmodule

// ==== design/ssm_group_accum.sv ====
/* lane reduction, accumulation over the tiles of a group and the
   final y = sum + xD with its one-cycle valid pulse */
module ssm_group_accum #(
    parameter int N_TILE = 4
) (
    input  logic         clk,
    input  logic         rstn,
    input  logic         hc_valid_i,
    input  ssm_pkg::fx_t hc_tile_i [N_TILE],
    input  logic         hc_last_i,
    input  ssm_pkg::fx_t xd_i,
    output ssm_pkg::fx_t y_o,
    output logic         y_valid_o
);

    // ====================
    // lane reduction
    ssm_pkg::acc_t lane_sum;   // exact, no saturation here

    always_comb begin
        lane_sum = '0;
        for (int n = 0; n < N_TILE; n++) begin
            lane_sum = lane_sum + ssm_pkg::acc_t'(hc_tile_i[n]);   // sign extend each lane
        end
    end

    // ====================
    // stage 1: tile sum
    logic          s1_valid;
    logic          s1_last;
    ssm_pkg::acc_t s1_sum;
    ssm_pkg::fx_t  s1_xd;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= hc_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (hc_valid_i) begin
            s1_sum  <= lane_sum;
            s1_last <= hc_last_i;
            s1_xd   <= xd_i;        // only looked at with the last tile
        end
    end

    // ====================
    // stage 2: group accumulate or emit
    ssm_pkg::acc_t grp_acc;    // sum of the earlier tiles of the group
    ssm_pkg::acc_t grp_total;  // everything that goes into y

    // the closing tile never enters grp_acc, it is added on the way out
    assign grp_total = grp_acc + s1_sum + ssm_pkg::acc_t'(s1_xd);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            grp_acc   <= '0;
            y_o       <= '0;
            y_valid_o <= 1'b0;
        end else begin
            y_valid_o <= 1'b0;      // pulse by default low
            if (s1_valid) begin
                if (s1_last) begin
                    y_o       <= ssm_pkg::fx_sat(grp_total);   // single clamp at the end
                    y_valid_o <= 1'b1;
                    grp_acc   <= '0;                           // ready for the next group
                end else begin
                    grp_acc   <= grp_acc + s1_sum;
                end
            end
        end
    end

endmodule

// ==== design/ssm_pkg.sv ====
/* q8.8 fixed-point format, pipeline structs and the saturating
   multiply, add and narrowing functions of the ssm block */
package ssm_pkg;

    // ====================
    // number format
    localparam int FX_W    = 16;   // data word
    localparam int FX_FRAC = 8;    // fraction bits of q8.8
    localparam int ACC_W   = 32;   // exact sums

    typedef logic signed [FX_W-1:0]  fx_t;
    typedef logic signed [ACC_W-1:0] acc_t;

    localparam fx_t FX_MAX = 16'sh7fff;   // +127.996
    localparam fx_t FX_MIN = 16'sh8000;   // -128.0

    // ====================
    // pipeline payloads

    // scalars that come with every tile
    typedef struct packed {
        fx_t dt;        // raw step
        fx_t dt_bias;   // step bias
        fx_t da;        // decay, already exponentiated
        fx_t x;         // channel input
        fx_t d;         // skip weight
    } tile_scalars_t;

    // scalar stage result, one per tile
    typedef struct packed {
        fx_t  dx;       // delta * x of this tile
        fx_t  xd;       // x * D of the group
        fx_t  da;
        logic first;    // first tile of its group
        logic last;     // last tile of its group
    } scalar_out_t;

    // ====================
    // arithmetic

    // clamp a wide value into the q8.8 range
    function automatic fx_t fx_sat(acc_t v);
        if (v > acc_t'(FX_MAX)) begin
            return FX_MAX;
        end
        if (v < acc_t'(FX_MIN)) begin
            return FX_MIN;
        end
        return fx_t'(v[FX_W-1:0]);
    endfunction

    // full product, arithmetic shift back to q8.8, then clamp
    function automatic fx_t fx_mul(fx_t a, fx_t b);
        acc_t prod;
        prod = a * b;                 // 16x16 signed fits in 32
        return fx_sat(prod >>> FX_FRAC);
    endfunction

    // saturating add of two q8.8 words
    function automatic fx_t fx_add(fx_t a, fx_t b);
        acc_t sum;
        sum = acc_t'(a) + acc_t'(b);  // no wrap in 32 bits
        return fx_sat(sum);
    endfunction

endpackage

// ==== design/ssm_scalar_stage.sv ====
/* scalar path: delta, dx and xD per tile, group position tags and
   first-tile capture of x and D, two register stages */
module ssm_scalar_stage #(
    parameter int N_TILE          = 4,
    parameter int TILES_PER_GROUP = 2
) (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   tile_valid_i,
    input  ssm_pkg::tile_scalars_t scalars_i,
    input  ssm_pkg::fx_t           b_i     [N_TILE],
    input  ssm_pkg::fx_t           c_i     [N_TILE],
    input  ssm_pkg::fx_t           hprev_i [N_TILE],
    output logic                   sc_valid_o,
    output ssm_pkg::scalar_out_t   sc_o,
    output ssm_pkg::fx_t           b_o     [N_TILE],
    output ssm_pkg::fx_t           c_o     [N_TILE],
    output ssm_pkg::fx_t           hprev_o [N_TILE]
);
    localparam int CNT_W = (TILES_PER_GROUP > 1) ? $clog2(TILES_PER_GROUP) : 1;

    // ====================
    // group position
    logic [CNT_W-1:0] tile_cnt;          // tiles taken so far in this group
    logic             is_first;
    logic             is_last;
    ssm_pkg::fx_t     x_hold;            // x of the first tile
    ssm_pkg::fx_t     d_hold;            // D of the first tile
    ssm_pkg::fx_t     x_grp;             // x used for xD
    ssm_pkg::fx_t     d_grp;             // D used for xD

    assign is_first = (tile_cnt == '0);
    assign is_last  = (tile_cnt == CNT_W'(TILES_PER_GROUP - 1));
    assign x_grp    = is_first ? scalars_i.x : x_hold;   // first tile bypasses the hold
    assign d_grp    = is_first ? scalars_i.d : d_hold;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            tile_cnt <= '0;
            x_hold   <= '0;
            d_hold   <= '0;
        end else if (tile_valid_i) begin
            if (is_last) begin
                tile_cnt <= '0;          // wrap for the next group
            end else begin
                tile_cnt <= tile_cnt + 1'b1;
            end
            if (is_first) begin
                x_hold <= scalars_i.x;   // later tiles leave x and D alone
                d_hold <= scalars_i.d;
            end
        end
    end

    // ====================
    // stage 1: delta, xD, tags
    logic         s1_valid;
    ssm_pkg::fx_t s1_delta;
    ssm_pkg::fx_t s1_x;                  // own x of the tile, for dx
    ssm_pkg::fx_t s1_xd;
    ssm_pkg::fx_t s1_da;
    logic         s1_first;
    logic         s1_last;
    ssm_pkg::fx_t s1_b     [N_TILE];
    ssm_pkg::fx_t s1_c     [N_TILE];
    ssm_pkg::fx_t s1_hprev [N_TILE];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            s1_valid   <= 1'b0;
            sc_valid_o <= 1'b0;
        end else begin
            s1_valid   <= tile_valid_i;
            sc_valid_o <= s1_valid;      // stage 2 strobe
        end
    end

    always_ff @(posedge clk) begin
        if (tile_valid_i) begin
            s1_delta <= ssm_pkg::fx_add(scalars_i.dt, scalars_i.dt_bias);
            s1_xd    <= ssm_pkg::fx_mul(x_grp, d_grp);
            s1_x     <= scalars_i.x;
            s1_da    <= scalars_i.da;
            s1_first <= is_first;
            s1_last  <= is_last;
            s1_b     <= b_i;             // lanes ride along with the scalars
            s1_c     <= c_i;
            s1_hprev <= hprev_i;
        end
        // stage 2: dx
        if (s1_valid) begin
            sc_o.dx    <= ssm_pkg::fx_mul(s1_delta, s1_x);
            sc_o.xd    <= s1_xd;
            sc_o.da    <= s1_da;
            sc_o.first <= s1_first;
            sc_o.last  <= s1_last;
            b_o        <= s1_b;
            c_o        <= s1_c;
            hprev_o    <= s1_hprev;
        end
    end

endmodule

// ==== design/ssm_state_update.sv ====
/* per-lane state recurrence h = dA*hprev + dx*B and the output
   projection h*C over one tile, three register stages */
module ssm_state_update #(
    parameter int N_TILE = 4
) (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 sc_valid_i,
    input  ssm_pkg::scalar_out_t sc_i,
    input  ssm_pkg::fx_t         b_i       [N_TILE],
    input  ssm_pkg::fx_t         c_i       [N_TILE],
    input  ssm_pkg::fx_t         hprev_i   [N_TILE],
    output logic                 hc_valid_o,
    output ssm_pkg::fx_t         hc_tile_o [N_TILE],
    output logic                 hc_last_o,
    output ssm_pkg::fx_t         xd_o
);
    // tile info that is carried, not computed, through the lanes
    typedef struct packed {
        logic         last;   // closes the group
        ssm_pkg::fx_t xd;     // added once per group downstream
    } side_t;

    // ====================
    // valid pipeline
    logic s1_valid;
    logic s2_valid;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            s1_valid   <= 1'b0;
            s2_valid   <= 1'b0;
            hc_valid_o <= 1'b0;
        end else begin
            s1_valid   <= sc_valid_i;
            s2_valid   <= s1_valid;
            hc_valid_o <= s2_valid;
        end
    end

    // ====================
    // stage 1: the two products per lane
    ssm_pkg::fx_t s1_dah [N_TILE];   // dA * hprev
    ssm_pkg::fx_t s1_dbx [N_TILE];   // dx * B
    ssm_pkg::fx_t s1_c   [N_TILE];
    side_t        s1_side;

    always_ff @(posedge clk) begin
        if (sc_valid_i) begin
            for (int n = 0; n < N_TILE; n++) begin
                s1_dah[n] <= ssm_pkg::fx_mul(sc_i.da, hprev_i[n]);   // dA broadcast over lanes
                s1_dbx[n] <= ssm_pkg::fx_mul(sc_i.dx, b_i[n]);       // dx broadcast too
            end
            s1_c         <= c_i;
            s1_side.last <= sc_i.last;
            s1_side.xd   <= sc_i.xd;
        end
    end

    // ====================
    // stage 2: next state
    ssm_pkg::fx_t s2_h [N_TILE];
    ssm_pkg::fx_t s2_c [N_TILE];
    side_t        s2_side;

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            for (int n = 0; n < N_TILE; n++) begin
                s2_h[n] <= ssm_pkg::fx_add(s1_dah[n], s1_dbx[n]);   // saturating
            end
            s2_c    <= s1_c;
            s2_side <= s1_side;
        end
    end

    // ====================
    // stage 3: projection on C
    always_ff @(posedge clk) begin
        if (s2_valid) begin
            for (int n = 0; n < N_TILE; n++) begin
                hc_tile_o[n] <= ssm_pkg::fx_mul(s2_h[n], s2_c[n]);
            end
            hc_last_o <= s2_side.last;
            xd_o      <= s2_side.xd;
        end
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the ssm block testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    -f ssm_block.f \
    --top-module ssm_block_tb \
    -o ssm_block_sim

./obj_dir/ssm_block_sim > sim.log 2>&1
cat sim.log

if grep -q "PASS: all tests" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see sim.log"
    exit 1
fi

// ==== ssm_block.f ====
+incdir+bench
design/ssm_pkg.sv
design/ssm_scalar_stage.sv
design/ssm_state_update.sv
design/ssm_group_accum.sv
design/ssm_block_top.sv
bench/ssm_block_tb.sv
